// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timing -j 0
TOP       ?= vregpack_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
RUN_OPTS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) *.sv
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_OPTS)

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
vregpack_pkg.sv
vregpack_narrow.sv
vregpack_buffer.sv
vregpack_write_stage.sv
vregpack_top.sv
vregpack_assertions.sv
vregpack_tb.sv

// ==== vregpack_assertions.sv ====
// packing unit checker
// reference model of the packing buffer and write stage, compared each cycle

`default_nettype none

module vregpack_assertions (
    input wire logic                                  clk_i,
    input wire logic                                  async_rst_ni,
    input wire logic                                  in_valid_i,
    input wire logic                                  in_ready_o,
    input wire logic [vregpack_pkg::INSTR_ID_W-1:0]   in_instr_id_i,
    input var vregpack_pkg::eew_e                     in_eew_i,
    input wire logic [vregpack_pkg::VADDR_W-1:0]      in_vaddr_i,
    input wire logic                                  in_res_store_i,
    input wire logic                                  in_res_valid_i,
    input wire logic                                  in_instr_done_i,
    input wire logic                                  in_res_shift_i,
    input wire logic                                  in_res_narrow_i,
    input wire logic                                  in_res_saturate_i,
    input wire logic                                  in_res_sig_i,
    input wire logic [vregpack_pkg::RES_W-1:0]        in_res_data_i,
    input wire logic [vregpack_pkg::RES_BE_W-1:0]     in_res_mask_i,
    input wire logic [vregpack_pkg::VREG_CNT-1:0]     pending_vreg_reads_i,
    input wire logic [vregpack_pkg::INSTR_ID_CNT-1:0] instr_spec_i,
    input wire logic [vregpack_pkg::INSTR_ID_CNT-1:0] instr_killed_i,
    input wire logic                                  vreg_wr_valid_o,
    input wire logic                                  vreg_wr_ready_i,
    input wire logic [vregpack_pkg::VADDR_W-1:0]      vreg_wr_addr_o,
    input wire logic [vregpack_pkg::BE_W-1:0]         vreg_wr_be_o,
    input wire logic [vregpack_pkg::VPORT_W-1:0]      vreg_wr_data_o,
    input wire logic                                  instr_done_valid_o,
    input wire logic [vregpack_pkg::INSTR_ID_W-1:0]   instr_done_id_o
);

    int          err_cnt = 0;  // watched by the testbench
    logic [63:0] ref_data;
    logic [7:0]  ref_be;
    logic [31:0] up_data;
    logic [3:0]  up_be;
    logic        st_valid, st_store, st_done, stall_ref;
    logic [2:0]  st_id;
    logic [4:0]  st_vaddr;

    // narrow one 16-bit element to a byte, clamping to the target range
    function automatic logic [7:0] to_byte(logic [15:0] e, logic sat, logic sg);
        int v;
        v = sg ? int'($signed(e)) : int'(e);
        if (sat && sg && v > 127) return 8'h7f;
        if (sat && sg && v < -128) return 8'h80;
        if (sat && !sg && v > 255) return 8'hff;
        return e[7:0];
    endfunction

    function automatic logic [15:0] to_half(logic [31:0] e, logic sat, logic sg);
        longint v;
        v = sg ? longint'($signed(e)) : longint'(e);
        if (sat && sg && v > 32767) return 16'h7fff;
        if (sat && sg && v < -32768) return 16'h8000;
        if (sat && !sg && v > 65535) return 16'hffff;
        return e[15:0];
    endfunction

    always_comb begin
        up_data = in_res_data_i;
        up_be   = in_res_mask_i;
        if (in_res_narrow_i) begin
            up_data = {16'h0, ref_data[63:48]};
            up_be   = {2'b00, ref_be[7:6]};
            if (in_eew_i == vregpack_pkg::EEW_16) begin
                up_data[31:16] = {to_byte(in_res_data_i[31:16], in_res_saturate_i, in_res_sig_i),
                                  to_byte(in_res_data_i[15:0], in_res_saturate_i, in_res_sig_i)};
                up_be[3:2]     = {in_res_mask_i[2], in_res_mask_i[0]};
            end else if (in_eew_i == vregpack_pkg::EEW_32) begin
                up_data[31:16] = to_half(in_res_data_i, in_res_saturate_i, in_res_sig_i);
                up_be[3:2]     = {2{in_res_mask_i[0]}};
            end
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            ref_data <= '0;
            ref_be   <= '0;
            st_valid <= 1'b0;
            st_store <= 1'b0;
            st_done  <= 1'b0;
            st_id    <= '0;
            st_vaddr <= '0;
        end else begin
            if (in_valid_i && in_ready_o && in_res_valid_i) begin
                ref_data <= in_res_shift_i ? {up_data, ref_data[63:32]} : {up_data, ref_data[31:0]};
                ref_be   <= in_res_shift_i ? {up_be, ref_be[7:4]} : {up_be, ref_be[3:0]};
            end
            if (in_ready_o) begin
                st_valid <= in_valid_i;
                st_store <= in_res_store_i;
                st_done  <= in_instr_done_i;
                st_id    <= in_instr_id_i;
                st_vaddr <= in_vaddr_i;
            end
        end
    end

    assign stall_ref = st_store & (pending_vreg_reads_i[st_vaddr] | instr_spec_i[st_id] |
                                   ~vreg_wr_ready_i);

    reset_idle: assert property (@(posedge clk_i)
        !async_rst_ni |-> !vreg_wr_valid_o && !instr_done_valid_o && in_ready_o)
        else begin err_cnt++; $error("reset_idle: outputs not idle during reset"); end

    wr_data: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        vreg_wr_data_o == ref_data && vreg_wr_be_o == ref_be)
        else begin
            err_cnt++;
            $error("ERROR wr_data expected %h/%h actual %h/%h", $sampled(ref_data),
                   $sampled(ref_be), $sampled(vreg_wr_data_o), $sampled(vreg_wr_be_o));
        end

    wr_valid: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        vreg_wr_valid_o == (st_valid && st_store && !stall_ref && !instr_killed_i[st_id]))
        else begin
            err_cnt++;
            $error("ERROR wr_valid expected %b actual %b",
                   $sampled(st_valid && st_store && !stall_ref && !instr_killed_i[st_id]),
                   $sampled(vreg_wr_valid_o));
        end

    done_pulse: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        instr_done_valid_o == (st_valid && st_done && !stall_ref) && instr_done_id_o == st_id)
        else begin
            err_cnt++;
            $error("ERROR done_pulse expected %b/%0d actual %b/%0d",
                   $sampled(st_valid && st_done && !stall_ref), $sampled(st_id),
                   $sampled(instr_done_valid_o), $sampled(instr_done_id_o));
        end

    ready_rule: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        in_ready_o == (!st_valid || !stall_ref) && vreg_wr_addr_o == st_vaddr)
        else begin
            err_cnt++;
            $error("ERROR ready_rule expected %b/%0d actual %b/%0d",
                   $sampled(!st_valid || !stall_ref), $sampled(st_vaddr),
                   $sampled(in_ready_o), $sampled(vreg_wr_addr_o));
        end

    stall_hold: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        st_valid && stall_ref |=> $stable(vreg_wr_data_o) && $stable(vreg_wr_be_o) &&
                                  $stable(vreg_wr_addr_o))
        else begin err_cnt++; $error("stall_hold: write port changed while stalled"); end

endmodule

bind vregpack_top vregpack_assertions vregpack_assertions_i (.*);

`default_nettype wire

// ==== vregpack_buffer.sv ====
// packing buffer
// data and byte enable shift registers that collect results until a store

`default_nettype none

module vregpack_buffer (
    input  wire logic                              clk_i,
    input  wire logic                              async_rst_ni,
    input  wire logic                              load_i,  // accepted valid result
    input  wire logic                              shift_i,
    input  wire logic [vregpack_pkg::RES_W-1:0]    upper_data_i,
    input  wire logic [vregpack_pkg::RES_BE_W-1:0] upper_be_i,
    output logic      [vregpack_pkg::VPORT_W-1:0]  buf_data_o,
    output logic      [vregpack_pkg::BE_W-1:0]     buf_be_o
);

    localparam int unsigned LO_W  = vregpack_pkg::VPORT_W - vregpack_pkg::RES_W;
    localparam int unsigned LO_BE = vregpack_pkg::BE_W - vregpack_pkg::RES_BE_W;

    logic [vregpack_pkg::VPORT_W-1:0] data_q, data_d;
    logic [vregpack_pkg::BE_W-1:0]    be_q, be_d;

    // new upper half always, lower half either shifted down or kept
    always_comb begin
        if (shift_i) begin
            data_d = {upper_data_i, data_q[vregpack_pkg::VPORT_W-1 -: LO_W]};
            be_d   = {upper_be_i, be_q[vregpack_pkg::BE_W-1 -: LO_BE]};
        end else begin
            data_d = {upper_data_i, data_q[LO_W-1:0]};
            be_d   = {upper_be_i, be_q[LO_BE-1:0]};
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            data_q <= '0;
            be_q   <= '0;
        end else if (load_i) begin
            data_q <= data_d;
            be_q   <= be_d;
        end
    end

    assign buf_data_o = data_q;
    assign buf_be_o   = be_q;

endmodule

`default_nettype wire

// ==== vregpack_narrow.sv ====
// result narrowing
// builds the upper half of the next packing buffer word, either from the full
// result or from narrowed elements with optional signed/unsigned saturation

`default_nettype none

module vregpack_narrow (
    input  var vregpack_pkg::eew_e                 eew_i,
    input  wire logic                              narrow_i,
    input  wire logic                              saturate_i,
    input  wire logic                              sig_i,
    input  wire logic [vregpack_pkg::RES_W-1:0]    res_data_i,
    input  wire logic [vregpack_pkg::RES_BE_W-1:0] res_mask_i,
    input  wire logic [15:0]                       buf_top_data_i, // top quarter of buffer
    input  wire logic [1:0]                        buf_top_be_i,
    output logic      [vregpack_pkg::RES_W-1:0]    upper_data_o,
    output logic      [vregpack_pkg::RES_BE_W-1:0] upper_be_o
);

    localparam int unsigned HALF   = vregpack_pkg::RES_W / 2;    // bit offset of narrowed part
    localparam int unsigned HALF_B = vregpack_pkg::RES_BE_W / 2;

    always_comb begin
        upper_data_o = res_data_i; // full width result by default
        upper_be_o   = res_mask_i;
        if (narrow_i) begin
            upper_data_o = '0;
            upper_be_o   = '0;
            // lower half continues from the top of the buffer
            upper_data_o[HALF-1:0]   = buf_top_data_i;
            upper_be_o[HALF_B-1:0]   = buf_top_be_i;
            unique case (eew_i)
                vregpack_pkg::EEW_16: begin
                    for (int j = 0; j < vregpack_pkg::RES_W / 16; j++) begin
                        upper_data_o[HALF + 8*j +: 8] = res_data_i[16*j +: 8];
                        upper_be_o[HALF_B + j]        = res_mask_i[2*j];
                        // discarded byte must equal the sign extension
                        if (saturate_i && (res_data_i[16*j + 8 +: 8] !=
                                           {8{sig_i & res_data_i[16*j + 7]}})) begin
                            upper_data_o[HALF + 8*j +: 8] = sig_i ?
                                {res_data_i[16*j + 15], {7{~res_data_i[16*j + 15]}}} : 8'hff;
                        end
                    end
                end
                vregpack_pkg::EEW_32: begin
                    upper_data_o[HALF +: 16]   = res_data_i[15:0];
                    upper_be_o[HALF_B +: 2]    = {2{res_mask_i[0]}};
                    if (saturate_i && (res_data_i[31:16] != {16{sig_i & res_data_i[15]}})) begin
                        upper_data_o[HALF +: 16] = sig_i ?
                            {res_data_i[31], {15{~res_data_i[31]}}} : 16'hffff;
                    end
                end
                vregpack_pkg::EEW_8: ;  // nothing narrower than a byte
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== vregpack_pkg.sv ====
// vector register packing package
// shared widths, counts and the element width encoding used by all blocks

`default_nettype none

package vregpack_pkg;

    // register write port
    localparam int unsigned VPORT_W = 64;          // write port data width
    localparam int unsigned BE_W    = VPORT_W / 8; // byte enables per write

    // one result from the execution unit
    localparam int unsigned RES_W    = 32;
    localparam int unsigned RES_BE_W = RES_W / 8;  // byte mask bits per result

    // register file addressing
    localparam int unsigned VADDR_W  = 5;
    localparam int unsigned VREG_CNT = 1 << VADDR_W; // 32 vector registers

    // instruction tracking
    localparam int unsigned INSTR_ID_W   = 3;
    localparam int unsigned INSTR_ID_CNT = 1 << INSTR_ID_W;

    // element width of the current instruction
    typedef enum logic [1:0] {
        EEW_8  = 2'b00,
        EEW_16 = 2'b01,
        EEW_32 = 2'b10
    } eew_e;

endpackage

`default_nettype wire

// ==== vregpack_tb.sv ====
// packing unit testbench
// directed packing and saturation items followed by seeded random traffic

`default_nettype none

module vregpack_tb;

    localparam int MAX_CYCLES = 2000;  // about 300 items plus stall allowance

    logic                clk_i = 1'b0;
    logic                async_rst_ni;
    logic                in_valid_i, in_ready_o;
    logic [2:0]          in_instr_id_i;
    vregpack_pkg::eew_e  in_eew_i;
    logic [4:0]          in_vaddr_i;
    logic                in_res_store_i, in_res_valid_i, in_instr_done_i;
    logic                in_res_shift_i, in_res_narrow_i, in_res_saturate_i, in_res_sig_i;
    logic [31:0]         in_res_data_i;
    logic [3:0]          in_res_mask_i;
    logic [31:0]         pending_vreg_reads_i;
    logic [7:0]          instr_spec_i, instr_killed_i;
    logic                vreg_wr_valid_o, vreg_wr_ready_i;
    logic [4:0]          vreg_wr_addr_o;
    logic [7:0]          vreg_wr_be_o;
    logic [63:0]         vreg_wr_data_o;
    logic                instr_done_valid_o;
    logic [2:0]          instr_done_id_o;
    int                  cycles = 0;
    logic                noise_en = 1'b0;

    vregpack_top vregpack_top_i (.*);

    always #50 clk_i = ~clk_i;

    // drive one item and wait until the unit takes it
    task automatic send(input logic st, input logic dn, input logic sh, input logic nw,
                        input logic sa, input logic sg, input vregpack_pkg::eew_e ew,
                        input logic [31:0] d, input logic [3:0] m, input logic rv);
        in_valid_i        <= 1'b1;
        in_res_valid_i    <= rv;
        in_res_store_i    <= st;
        in_instr_done_i   <= dn;
        in_res_shift_i    <= sh;
        in_res_narrow_i   <= nw;
        in_res_saturate_i <= sa;
        in_res_sig_i      <= sg;
        in_eew_i          <= ew;
        in_res_data_i     <= d;
        in_res_mask_i     <= m;
        in_instr_id_i     <= 3'($urandom);
        in_vaddr_i        <= 5'($urandom);
        @(negedge clk_i);
        while (!in_ready_o) @(negedge clk_i);
        @(posedge clk_i);
        in_valid_i <= 1'b0;
    endtask

    // random hazards, speculation, kills and port back-pressure
    always @(posedge clk_i) begin
        if (noise_en) begin
            pending_vreg_reads_i <= ($urandom % 4 == 0) ? $urandom : '0;
            instr_spec_i         <= ($urandom % 4 == 0) ? 8'($urandom) : '0;
            instr_killed_i       <= ($urandom % 3 == 0) ? 8'($urandom) : '0;
            vreg_wr_ready_i      <= ($urandom % 4 != 0);
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Verification failed");
            $fatal(1, "timeout after %0d cycles", cycles);
        end
    end

    always @(negedge clk_i) begin
        if (vregpack_top_i.vregpack_assertions_i.err_cnt != 0) begin
            $display("Verification failed");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        logic nw;
        void'($urandom(32'h7166));
        async_rst_ni = 1'b0;
        in_valid_i = 1'b0;
        in_instr_id_i = '0;
        in_eew_i = vregpack_pkg::EEW_8;
        in_vaddr_i = '0;
        {in_res_store_i, in_res_valid_i, in_instr_done_i, in_res_shift_i} = '0;
        {in_res_narrow_i, in_res_saturate_i, in_res_sig_i} = '0;
        in_res_data_i = '0;
        in_res_mask_i = '0;
        pending_vreg_reads_i = '0;
        instr_spec_i = '0;
        instr_killed_i = '0;
        vreg_wr_ready_i = 1'b1;
        repeat (2) @(posedge clk_i);
        async_rst_ni <= 1'b1;
        @(posedge clk_i);
        noise_en <= 1'b1;
        // full width pair with B above A
        send(0, 0, 1, 0, 0, 0, vregpack_pkg::EEW_32, 32'h1111_aaaa, 4'h5, 1);
        send(1, 1, 1, 0, 0, 0, vregpack_pkg::EEW_32, 32'h2222_bbbb, 4'ha, 1);
        // saturating narrowing corners
        send(1, 0, 0, 1, 1, 1, vregpack_pkg::EEW_16, 32'h0180_ff7f, 4'hf, 1);
        send(1, 0, 0, 1, 1, 0, vregpack_pkg::EEW_16, 32'h00ff_0100, 4'h5, 1);
        send(1, 0, 0, 1, 1, 1, vregpack_pkg::EEW_32, 32'h8000_0000, 4'h1, 1);
        send(1, 0, 0, 1, 1, 1, vregpack_pkg::EEW_32, 32'h0001_0000, 4'h1, 1);
        send(1, 1, 0, 1, 1, 0, vregpack_pkg::EEW_32, 32'h0001_0000, 4'h1, 1);
        for (int i = 0; i < 300; i++) begin
            nw = ($urandom % 2 == 0);
            send($urandom % 2 == 0, $urandom % 3 == 0, $urandom % 2 == 0, nw,
                 $urandom % 2 == 0, $urandom % 2 == 0,
                 ($urandom % 2 == 0) ? vregpack_pkg::EEW_16 : vregpack_pkg::EEW_32,
                 $urandom, 4'($urandom), $urandom % 8 != 0);
        end
        // last edge checks settle before the verdict
        repeat (4) @(negedge clk_i);
        if (vregpack_top_i.vregpack_assertions_i.err_cnt == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "assertion failures at end of run");
        end
    end

endmodule

`default_nettype wire

// ==== vregpack_top.sv ====
// vector register packing unit
// packs 32-bit execution results into 64-bit vector register writes,
// with element narrowing, saturation and a single stalling write stage

`default_nettype none

module vregpack_top (
    input  wire logic                                  clk_i,
    input  wire logic                                  async_rst_ni,

    // result input
    input  wire logic                                  in_valid_i,
    output logic                                       in_ready_o,
    input  wire logic [vregpack_pkg::INSTR_ID_W-1:0]   in_instr_id_i,
    input  var vregpack_pkg::eew_e                     in_eew_i,
    input  wire logic [vregpack_pkg::VADDR_W-1:0]      in_vaddr_i,
    input  wire logic                                  in_res_store_i,
    input  wire logic                                  in_res_valid_i,
    input  wire logic                                  in_instr_done_i,
    input  wire logic                                  in_res_shift_i,
    input  wire logic                                  in_res_narrow_i,
    input  wire logic                                  in_res_saturate_i,
    input  wire logic                                  in_res_sig_i,     // signed saturation
    input  wire logic [vregpack_pkg::RES_W-1:0]        in_res_data_i,
    input  wire logic [vregpack_pkg::RES_BE_W-1:0]     in_res_mask_i,

    // hazard and speculation state
    input  wire logic [vregpack_pkg::VREG_CNT-1:0]     pending_vreg_reads_i,
    input  wire logic [vregpack_pkg::INSTR_ID_CNT-1:0] instr_spec_i,
    input  wire logic [vregpack_pkg::INSTR_ID_CNT-1:0] instr_killed_i,

    // register file write port
    output logic                                       vreg_wr_valid_o,
    input  wire logic                                  vreg_wr_ready_i,
    output logic      [vregpack_pkg::VADDR_W-1:0]      vreg_wr_addr_o,
    output logic      [vregpack_pkg::BE_W-1:0]         vreg_wr_be_o,
    output logic      [vregpack_pkg::VPORT_W-1:0]      vreg_wr_data_o,

    // instruction completion
    output logic                                       instr_done_valid_o,
    output logic      [vregpack_pkg::INSTR_ID_W-1:0]   instr_done_id_o
);

    logic                              load;
    logic [vregpack_pkg::RES_W-1:0]    upper_data;
    logic [vregpack_pkg::RES_BE_W-1:0] upper_be;
    logic [vregpack_pkg::VPORT_W-1:0]  buf_data;
    logic [vregpack_pkg::BE_W-1:0]     buf_be;

    vregpack_narrow vregpack_narrow_i (
        .eew_i          (in_eew_i),
        .narrow_i       (in_res_narrow_i),
        .saturate_i     (in_res_saturate_i),
        .sig_i          (in_res_sig_i),
        .res_data_i     (in_res_data_i),
        .res_mask_i     (in_res_mask_i),
        .buf_top_data_i (buf_data[vregpack_pkg::VPORT_W-1 -: 16]),
        .buf_top_be_i   (buf_be[vregpack_pkg::BE_W-1 -: 2]),
        .upper_data_o   (upper_data),
        .upper_be_o     (upper_be)
    );

    vregpack_buffer vregpack_buffer_i (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .load_i       (load),
        .shift_i      (in_res_shift_i),
        .upper_data_i (upper_data),
        .upper_be_i   (upper_be),
        .buf_data_o   (buf_data),
        .buf_be_o     (buf_be)
    );

    vregpack_write_stage vregpack_write_stage_i (
        .clk_i                (clk_i),
        .async_rst_ni         (async_rst_ni),
        .in_valid_i           (in_valid_i),
        .in_res_valid_i       (in_res_valid_i),
        .in_res_store_i       (in_res_store_i),
        .in_instr_done_i      (in_instr_done_i),
        .in_instr_id_i        (in_instr_id_i),
        .in_vaddr_i           (in_vaddr_i),
        .pending_vreg_reads_i (pending_vreg_reads_i),
        .instr_spec_i         (instr_spec_i),
        .instr_killed_i       (instr_killed_i),
        .vreg_wr_ready_i      (vreg_wr_ready_i),
        .in_ready_o           (in_ready_o),
        .load_o               (load),
        .vreg_wr_valid_o      (vreg_wr_valid_o),
        .vreg_wr_addr_o       (vreg_wr_addr_o),
        .instr_done_valid_o   (instr_done_valid_o),
        .instr_done_id_o      (instr_done_id_o)
    );

    // write data is the packed buffer itself
    assign vreg_wr_data_o = buf_data;
    assign vreg_wr_be_o   = buf_be;

endmodule

`default_nettype wire

// ==== vregpack_write_stage.sv ====
// register write stage
// holds one item, applies the stall rule and drives the register write,
// the instruction done pulse and the buffer load enable

`default_nettype none

module vregpack_write_stage (
    input  wire logic                                  clk_i,
    input  wire logic                                  async_rst_ni,
    input  wire logic                                  in_valid_i,
    input  wire logic                                  in_res_valid_i,
    input  wire logic                                  in_res_store_i,
    input  wire logic                                  in_instr_done_i,
    input  wire logic [vregpack_pkg::INSTR_ID_W-1:0]   in_instr_id_i,
    input  wire logic [vregpack_pkg::VADDR_W-1:0]      in_vaddr_i,
    input  wire logic [vregpack_pkg::VREG_CNT-1:0]     pending_vreg_reads_i,
    input  wire logic [vregpack_pkg::INSTR_ID_CNT-1:0] instr_spec_i,
    input  wire logic [vregpack_pkg::INSTR_ID_CNT-1:0] instr_killed_i,
    input  wire logic                                  vreg_wr_ready_i,
    output logic                                       in_ready_o,
    output logic                                       load_o,
    output logic                                       vreg_wr_valid_o,
    output logic      [vregpack_pkg::VADDR_W-1:0]      vreg_wr_addr_o,
    output logic                                       instr_done_valid_o,
    output logic      [vregpack_pkg::INSTR_ID_W-1:0]   instr_done_id_o
);

    logic                                valid_q;
    logic                                store_q;
    logic                                done_q;
    logic [vregpack_pkg::INSTR_ID_W-1:0] instr_id_q;
    logic [vregpack_pkg::VADDR_W-1:0]    vaddr_q;
    logic                                stall;
    logic                                ready;

    // a store waits for pending reads of its register, speculation and the port
    assign stall = store_q & (pending_vreg_reads_i[vaddr_q] |
                              instr_spec_i[instr_id_q] |
                              ~vreg_wr_ready_i);
    assign ready = ~valid_q | ~stall;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q    <= 1'b0;
            store_q    <= 1'b0;
            done_q     <= 1'b0;
            instr_id_q <= '0;
            vaddr_q    <= '0;
        end else if (ready) begin
            valid_q    <= in_valid_i;  // bubble when nothing is offered
            store_q    <= in_res_store_i;
            done_q     <= in_instr_done_i;
            instr_id_q <= in_instr_id_i;
            vaddr_q    <= in_vaddr_i;
        end
    end

    assign in_ready_o = ready;
    assign load_o     = ready & in_valid_i & in_res_valid_i; // buffer takes the result

    // killed IDs still finish, only the write itself is dropped
    assign vreg_wr_valid_o    = valid_q & store_q & ~stall & ~instr_killed_i[instr_id_q];
    assign vreg_wr_addr_o     = vaddr_q;
    assign instr_done_valid_o = valid_q & done_q & ~stall;
    assign instr_done_id_o    = instr_id_q;

endmodule

`default_nettype wire
